// File: design/tcb_cmd_issue.sv
`include "tcb_defines.svh"

module tcb_cmd_issue
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     arst_n,
  // command side
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  input  tcb_cmd_t cmd,
  // bus request side
  output logic     req_vld,
  input  logic     req_rdy,
  output tcb_req_t req
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // bytes in the current command
  int unsigned cmd_nby;
  // request built from the command
  tcb_req_t    req_nxt;
  // command handshake
  logic        cmd_trn;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // register free, or emptied this cycle
  assign cmd_rdy = ~req_vld | req_rdy;
  assign cmd_trn = cmd_vld & cmd_rdy;

  //////////////////////////////
  // command decode
  //////////////////////////////

  // byte count from size code
  always_comb begin
    unique case (cmd.size)
      TCB_SIZE_BYTE: cmd_nby = 1;
      TCB_SIZE_HALF: cmd_nby = 2;
      TCB_SIZE_WORD: cmd_nby = 4;
      default:       cmd_nby = `TCB_BEW;
    endcase
  end

  always_comb begin
    req_nxt.wen = (cmd.op == TCB_OP_WRITE);
    req_nxt.adr = cmd.adr;
    // enables stay in transfer order
    req_nxt.ben = '0;
    for (int unsigned b = 0; b < `TCB_BEW; b++) begin
      req_nxt.ben[b] = (b < cmd_nby);
    end
    // byte b goes to lane (adr+b) mod BEW
    req_nxt.wdt = '0;
    for (int unsigned b = 0; b < `TCB_BEW; b++) begin
      req_nxt.wdt[tcb_lane(cmd.adr, b)*8 +: 8] = cmd.wdt[b*8 +: 8];
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // valid flag
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      req_vld <= 1'b0;
    end else if (cmd_rdy) begin
      req_vld <= cmd_vld;
    end
  end

  // payload, loaded only on handshake
  always_ff @(posedge tcb) begin
    if (cmd_trn) begin
      req <= req_nxt;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // stalled request must hold
  a_req_stable: assert property (
    @(posedge tcb) disable iff (!arst_n)
    req_vld && !req_rdy |=> req_vld && $stable(req)
  ) else $error("request changed while stalled");

endmodule

// File: design/tcb_defines.svh
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

//////////////////////////////
// bus geometry
//////////////////////////////

// address width in bits
`define TCB_ABW 16
// data width in bits
`define TCB_DBW 32
// one enable per data byte
`define TCB_BEW (`TCB_DBW/8)

//////////////////////////////
// storage sizes
//////////////////////////////

// request FIFO entries
`define TCB_FIFO_DEPTH 4
// memory size in bytes
`define TCB_MEM_SZ 256

`endif

// File: design/tcb_mem.sv
`include "tcb_defines.svh"

module tcb_mem
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     arst_n,
  // bus request side
  input  logic     req_vld,
  output logic     req_rdy,
  input  tcb_req_t req,
  // response side
  output logic     rsp_vld,
  input  logic     rsp_rdy,
  output tcb_rsp_t rsp
);

  localparam int unsigned MSZ = `TCB_MEM_SZ;

  //////////////////////////////
  // local signals
  //////////////////////////////

  // byte array
  logic [7:0]          mem_q [MSZ];
  // request accepted this cycle
  logic                req_trn;
  // read data before the register
  logic [`TCB_DBW-1:0] rdt_nxt;

  // byte address of transfer byte b, linear with wrap
  function automatic int unsigned byte_idx(
    input logic [`TCB_ABW-1:0] adr,
    input int unsigned         b
  );
    return (int'(adr) + b) % MSZ;
  endfunction

  //////////////////////////////
  // handshake
  //////////////////////////////

  // response slot free or draining
  assign req_rdy = ~rsp_vld | rsp_rdy;
  assign req_trn = req_vld & req_rdy;

  //////////////////////////////
  // write access
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (req_trn && req.wen) begin
      for (int unsigned b = 0; b < `TCB_BEW; b++) begin
        // lane wraps inside the word, address does not
        if (req.ben[b]) begin
          mem_q[byte_idx(req.adr, b)] <= req.wdt[tcb_lane(req.adr, b)*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // read access
  //////////////////////////////

  // disabled lanes and writes give zero
  always_comb begin
    rdt_nxt = '0;
    if (!req.wen) begin
      for (int unsigned b = 0; b < `TCB_BEW; b++) begin
        if (req.ben[b]) begin
          rdt_nxt[tcb_lane(req.adr, b)*8 +: 8] = mem_q[byte_idx(req.adr, b)];
        end
      end
    end
  end

  //////////////////////////////
  // response register
  //////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
    end else if (req_rdy) begin
      rsp_vld <= req_vld;
    end
  end

  // payload, sampled with the old array contents
  always_ff @(posedge tcb) begin
    if (req_trn) begin
      rsp.op  <= req.wen ? TCB_OP_WRITE : TCB_OP_READ;
      rsp.rdt <= rdt_nxt;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // issuer never sends an empty transfer
  a_ben_nonzero: assert property (
    @(posedge tcb) disable iff (!arst_n)
    req_trn |-> req.ben != '0
  ) else $error("accepted request without byte enables");

  // held response keeps its payload
  a_rsp_stable: assert property (
    @(posedge tcb) disable iff (!arst_n)
    rsp_vld && !rsp_rdy |=> rsp_vld && $stable(rsp)
  ) else $error("response changed while stalled");

endmodule

// File: design/tcb_pkg.sv
`include "tcb_defines.svh"

package tcb_pkg;

  //////////////////////////////
  // encodings
  //////////////////////////////

  // transfer direction
  typedef enum logic {
    TCB_OP_READ  = 1'b0,
    TCB_OP_WRITE = 1'b1
  } tcb_op_t;

  // transfer size, log2 of byte count
  typedef enum logic [1:0] {
    TCB_SIZE_BYTE = 2'd0,
    TCB_SIZE_HALF = 2'd1,
    TCB_SIZE_WORD = 2'd2
  } tcb_size_t;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // command from outside, data in transfer order
  typedef struct packed {
    tcb_op_t                op;
    tcb_size_t              size;
    logic [`TCB_ABW-1:0]    adr;
    logic [`TCB_DBW-1:0]    wdt;
  } tcb_cmd_t;

  // bus request, ben in transfer order, wdt in lane order
  typedef struct packed {
    logic                   wen;
    logic [`TCB_ABW-1:0]    adr;
    logic [`TCB_BEW-1:0]    ben;
    logic [`TCB_DBW-1:0]    wdt;
  } tcb_req_t;

  // response, rdt in lane order
  typedef struct packed {
    tcb_op_t                op;
    logic [`TCB_DBW-1:0]    rdt;
  } tcb_rsp_t;

  // lane carrying transfer byte b
  function automatic int unsigned tcb_lane(
    input logic [`TCB_ABW-1:0] adr,
    input int unsigned         b
  );
    return (int'(adr) + b) % `TCB_BEW;
  endfunction

endpackage

// File: design/tcb_req_fifo.sv
`include "tcb_defines.svh"

module tcb_req_fifo
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     arst_n,
  // write side
  input  logic     in_vld,
  output logic     in_rdy,
  input  tcb_req_t in,
  // read side
  output logic     out_vld,
  input  logic     out_rdy,
  output tcb_req_t out
);

  localparam int unsigned DEPTH = `TCB_FIFO_DEPTH;
  localparam int unsigned PTW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  //////////////////////////////
  // storage and pointers
  //////////////////////////////

  tcb_req_t         fifo_q [DEPTH];
  logic [PTW-1:0]   wr_ptr;
  logic [PTW-1:0]   rd_ptr;
  // occupancy with one extra bit for full
  logic [PTW:0]     cnt;

  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (cnt == (PTW+1)'(DEPTH));
  assign empty = (cnt == '0);

  // full is fine while the head leaves
  assign in_rdy  = ~full | out_rdy;
  assign out_vld = ~empty;

  assign push = in_vld & in_rdy;
  assign pop  = out_vld & out_rdy;

  // head entry with no bypass from input
  assign out = fifo_q[rd_ptr];

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // pointers wrap at depth
      if (push) begin
        wr_ptr <= (wr_ptr == PTW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // count moves only on one-sided traffic
      if (push && !pop) begin
        cnt <= cnt + 1'b1;
      end else if (pop && !push) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // entry write
  always_ff @(posedge tcb) begin
    if (push) begin
      fifo_q[wr_ptr] <= in;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // occupancy past depth means a push into full or a pop from empty
  a_cnt_range: assert property (
    @(posedge tcb) disable iff (!arst_n)
    cnt <= (PTW+1)'(DEPTH)
  ) else $error("FIFO occupancy out of range");

  // write pointer leads read pointer by the occupancy
  a_ptr_sync: assert property (
    @(posedge tcb) disable iff (!arst_n)
    wr_ptr == PTW'((32'(rd_ptr) + 32'(cnt)) % DEPTH)
  ) else $error("FIFO pointers disagree with occupancy");

endmodule

// File: design/tcb_subsys_top.sv
module tcb_subsys_top
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     arst_n,
  // command input
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  input  tcb_cmd_t cmd,
  // response output
  output logic     rsp_vld,
  input  logic     rsp_rdy,
  output tcb_rsp_t rsp
);

  //////////////////////////////
  // internal links
  //////////////////////////////

  // issuer to FIFO
  logic     iss_vld;
  logic     iss_rdy;
  tcb_req_t iss_req;

  // FIFO to memory
  logic     mem_vld;
  logic     mem_rdy;
  tcb_req_t mem_req;

  //////////////////////////////
  // pipeline
  //////////////////////////////

  tcb_cmd_issue i_cmd_issue (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .cmd     (cmd),
    .req_vld (iss_vld),
    .req_rdy (iss_rdy),
    .req     (iss_req)
  );

  // decouples issue from memory stalls
  tcb_req_fifo i_req_fifo (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (iss_vld),
    .in_rdy  (iss_rdy),
    .in      (iss_req),
    .out_vld (mem_vld),
    .out_rdy (mem_rdy),
    .out     (mem_req)
  );

  tcb_mem i_mem (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .req_vld (mem_vld),
    .req_rdy (mem_rdy),
    .req     (mem_req),
    .rsp_vld (rsp_vld),
    .rsp_rdy (rsp_rdy),
    .rsp     (rsp)
  );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f sim.f --top-module tcb_subsys_tb -o tcb_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/tcb_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Everything OK" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// File: sim.f
+incdir+design
design/tcb_pkg.sv
design/tcb_cmd_issue.sv
design/tcb_req_fifo.sv
design/tcb_mem.sv
design/tcb_subsys_top.sv
tests/tcb_subsys_tb.sv

// File: tests/tcb_subsys_tb.sv
`include "tcb_defines.svh"

module tcb_subsys_tb
  import tcb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RST_CYCLES = 10;
  // commands per test
  localparam int unsigned WORD_CMDS  = 128;
  localparam int unsigned SUB_CMDS   = 20;
  localparam int unsigned WRAP_CMDS  = 12;
  localparam int unsigned RAND_CMDS  = 300;
  localparam int unsigned N_CMDS     = WORD_CMDS + SUB_CMDS + WRAP_CMDS + RAND_CMDS;

  logic        tcb;
  logic        arst_n;
  logic        cmd_vld;
  logic        cmd_rdy;
  tcb_cmd_t    cmd;
  logic        rsp_vld;
  logic        rsp_rdy;
  tcb_rsp_t    rsp;

  // reference memory and expected responses
  logic [7:0]  model_mem [`TCB_MEM_SZ];
  tcb_rsp_t    exp_q [$];
  integer      seed = 32'hfb57_7ca8;
  integer      bp_seed;
  logic        bp_en;
  int unsigned n_cmd;
  int unsigned n_rsp;
  int unsigned n_err;
  int unsigned tests_pass;
  int unsigned tests_fail;

  tcb_subsys_top i_dut (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .cmd     (cmd),
    .rsp_vld (rsp_vld),
    .rsp_rdy (rsp_rdy),
    .rsp     (rsp)
  );

  // 20 ns clock
  initial begin
    tcb = 1'b0;
    forever #10 tcb = ~tcb;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic tcb_cmd_t make_cmd(
    input tcb_op_t             op,
    input tcb_size_t           size,
    input logic [`TCB_ABW-1:0] adr,
    input logic [`TCB_DBW-1:0] wdt
  );
    tcb_cmd_t c;
    c.op   = op;
    c.size = size;
    c.adr  = adr;
    c.wdt  = wdt;
    return c;
  endfunction

  // bytes go linear in memory, lanes wrap in the word
  function automatic tcb_rsp_t ref_apply(input tcb_cmd_t c);
    tcb_rsp_t    r;
    int unsigned nby;
    int unsigned idx;
    int unsigned lane;
    r.op  = c.op;
    r.rdt = '0;
    case (c.size)
      TCB_SIZE_BYTE: nby = 1;
      TCB_SIZE_HALF: nby = 2;
      default:       nby = `TCB_BEW;
    endcase
    for (int unsigned b = 0; b < nby; b++) begin
      idx  = (32'(c.adr) + b) % `TCB_MEM_SZ;
      lane = (32'(c.adr) + b) % `TCB_BEW;
      if (c.op == TCB_OP_WRITE) begin
        model_mem[idx] = c.wdt[8*b +: 8];
      end else begin
        r.rdt[8*lane +: 8] = model_mem[idx];
      end
    end
    return r;
  endfunction

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // hold the command until the handshake edge, then idle for gap cycles
  task automatic send_cmd(input tcb_cmd_t c, input int unsigned gap);
    @(negedge tcb);
    cmd_vld = 1'b1;
    cmd     = c;
    do @(posedge tcb); while (!cmd_rdy);
    exp_q.push_back(ref_apply(c));
    n_cmd++;
    if (gap > 0) begin
      @(negedge tcb);
      cmd_vld = 1'b0;
      repeat (gap - 1) @(negedge tcb);
    end
  endtask

  // stop issuing, wait for all responses
  task automatic drain();
    @(negedge tcb);
    cmd_vld = 1'b0;
    while (exp_q.size() != 0) @(negedge tcb);
  endtask

  task automatic end_test(input string name, input int unsigned err0);
    if (n_err == err0) begin
      tests_pass++;
      $display("test %s done, no errors", name);
    end else begin
      tests_fail++;
      $display("test %s done, %0d errors", name, n_err - err0);
    end
  endtask

  //////////////////////////////
  // response side
  //////////////////////////////

  // random back-pressure, otherwise always ready
  initial begin
    rsp_rdy = 1'b1;
    forever begin
      @(negedge tcb);
      rsp_rdy = bp_en ? (($random(bp_seed) & 3) != 0) : 1'b1;
    end
  end

  // compare each response with the oldest expected one
  always @(posedge tcb) begin : check_rsp
    tcb_rsp_t e;
    if (arst_n && rsp_vld && rsp_rdy) begin
      n_rsp++;
      assert (exp_q.size() > 0) else begin
        $display("response at %0t arrived with no command outstanding", $time);
        n_err++;
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        assert (rsp.op === e.op) else begin
          $display("MISMATCH t=%0t rsp.op expected=%0d actual=%0d", $time, e.op, rsp.op);
          n_err++;
        end
        assert (rsp.rdt === e.rdt) else begin
          $display("MISMATCH t=%0t rsp.rdt expected=%h actual=%h", $time, e.rdt, rsp.rdt);
          n_err++;
        end
      end
    end
  end

  // limit scales with the command count
  initial begin : watchdog
    repeat (RST_CYCLES + N_CMDS * 50) @(posedge tcb);
    $display("timeout, %0d responses still outstanding", exp_q.size());
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : main
    logic [31:0] rnd;
    tcb_op_t     op;
    tcb_size_t   size;
    int unsigned gap;
    int unsigned err0;
    arst_n     = 1'b0;
    cmd_vld    = 1'b0;
    cmd        = '0;
    bp_en      = 1'b0;
    bp_seed    = ~seed;
    n_cmd      = 0;
    n_rsp      = 0;
    n_err      = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (RST_CYCLES) @(negedge tcb);
    arst_n = 1'b1;

    // idle outputs before any command
    err0 = n_err;
    assert (rsp_vld === 1'b0) else begin
      $display("MISMATCH t=%0t rsp_vld expected=0 actual=%b", $time, rsp_vld);
      n_err++;
    end
    assert (cmd_rdy === 1'b1) else begin
      $display("MISMATCH t=%0t cmd_rdy expected=1 actual=%b", $time, cmd_rdy);
      n_err++;
    end
    end_test("reset", err0);

    // fills the whole memory, so later reads are defined
    err0 = n_err;
    for (int unsigned i = 0; i < WORD_CMDS / 2; i++) begin
      rnd = $random(seed);
      send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_WORD, 16'(i * 4), rnd), 0);
    end
    for (int unsigned i = 0; i < WORD_CMDS / 2; i++) begin
      send_cmd(make_cmd(TCB_OP_READ, TCB_SIZE_WORD, 16'(i * 4), '0), 0);
    end
    drain();
    end_test("word", err0);

    // byte and half writes merge into the words, then every size and offset
    err0 = n_err;
    for (int unsigned o = 0; o < 4; o++) begin
      rnd = $random(seed);
      send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_BYTE, 16'(8'h40 + o), rnd), 0);
      send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_HALF, 16'(8'h44 + o), ~rnd), 1);
    end
    for (int unsigned o = 0; o < 4; o++) begin
      send_cmd(make_cmd(TCB_OP_READ, TCB_SIZE_BYTE, 16'(8'h40 + o), '0), 0);
      send_cmd(make_cmd(TCB_OP_READ, TCB_SIZE_HALF, 16'(8'h40 + o), '0), 0);
      send_cmd(make_cmd(TCB_OP_READ, TCB_SIZE_WORD, 16'(8'h40 + o), '0), 0);
    end
    drain();
    end_test("sub-word", err0);

    // misaligned lanes, then aliasing past the memory end
    err0 = n_err;
    send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_WORD, 16'h0081, 32'h1122_3344), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_WORD, 16'h0081, '0), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_WORD, 16'h0080, '0), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_WORD, 16'h0084, '0), 0);
    send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_HALF, 16'h0083, 32'h0000_a55a), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_HALF, 16'h0083, '0), 0);
    send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_WORD, 16'h01f0, 32'hdead_beef), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_WORD, 16'h00f0, '0), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_WORD, 16'hfff0, '0), 0);
    send_cmd(make_cmd(TCB_OP_WRITE, TCB_SIZE_WORD, 16'h00fe, 32'hcafe_f00d), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_WORD, 16'h03fe, '0), 0);
    send_cmd(make_cmd(TCB_OP_READ,  TCB_SIZE_BYTE, 16'h0001, '0), 0);
    drain();
    end_test("wrap", err0);

    // random mix with gaps and back-pressure
    err0  = n_err;
    bp_en = 1'b1;
    for (int unsigned i = 0; i < RAND_CMDS; i++) begin
      rnd = $random(seed);
      op  = rnd[0] ? TCB_OP_WRITE : TCB_OP_READ;
      gap = (rnd[3:1] == 3'd0) ? 32'(rnd[5:4]) + 1 : 0;
      case (rnd[31:16] % 16'd3)
        16'd0:   size = TCB_SIZE_BYTE;
        16'd1:   size = TCB_SIZE_HALF;
        default: size = TCB_SIZE_WORD;
      endcase
      rnd = $random(seed);
      send_cmd(make_cmd(op, size, rnd[15:0], $random(seed)), gap);
    end
    drain();
    bp_en = 1'b0;
    end_test("random", err0);

    // a few idle cycles to catch stray responses
    repeat (5) @(negedge tcb);
    assert (exp_q.size() == 0) else begin
      $display("%0d expected responses never arrived", exp_q.size());
      n_err++;
    end
    assert (n_rsp == n_cmd) else begin
      $display("got %0d responses for %0d commands", n_rsp, n_cmd);
      n_err++;
    end
    $display("tests passed %0d failed %0d, commands %0d responses %0d errors %0d",
             tests_pass, tests_fail, n_cmd, n_rsp, n_err);
    if (n_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
